//--- Bender.yml
package:
  name: console_control

sources:
  - files:
      - source/spy_pkg.sv
      - source/mach_pkg.sv
      - source/spy_port.sv
      - source/overlord.sv
      - source/stat_counter.sv
      - source/cycle_sequencer.sv
      - source/console_top.sv
  - target: test
    files:
      - verification/console_tb.sv

//--- sim.f
source/spy_pkg.sv
source/mach_pkg.sv
source/spy_port.sv
source/overlord.sv
source/stat_counter.sv
source/cycle_sequencer.sv
source/console_top.sv
verification/console_tb.sv

//--- source/console_top.sv
/* Console control top level. Host spy accesses are single-cycle strobes;
   mem_wait is the only stall. */

module console_top
   import spy_pkg::*, mach_pkg::*;
(
   input  logic                 clk,
   input  logic                 reset,
   input  spy_wr_t              spy_wr,
   input  spy_rd_t              spy_rd,
   input  logic                 boot,
   input  logic                 set_promdisable,
   input  logic                 mem_wait,
   input  logic                 parity_error,
   output logic [15:0]          spy_rdata,
   output logic                 spy_rvalid,
   output opc_ctl_t             opc_ctl,
   output mode_t                mode,
   output logic                 idebug,
   output logic                 nop11,
   output mach_status_t         status,
   output logic [UPC_WIDTH-1:0] upc
);

   spy_ld_t     ld;
   logic [15:0] scratch;
   logic [15:0] stat_count;
   logic        state_fetch;
   logic        waiting;
   logic        errhalt;
   logic        statstop;
   logic        stat_ovf;
   logic        stat_enb;
   logic        machrun;

   spy_port spy_port_i (
      .clk(clk), .reset(reset), .spy_wr(spy_wr), .spy_rd(spy_rd),
      .scratch(scratch), .status(status), .upc(upc), .stat_count(stat_count),
      .ld(ld), .spy_rdata(spy_rdata), .spy_rvalid(spy_rvalid)
   );

   overlord overlord_i (
      .clk(clk), .reset(reset), .ld(ld), .spy_data(spy_wr.data),
      .boot(boot), .set_promdisable(set_promdisable), .state_fetch(state_fetch),
      .waiting(waiting), .errhalt(errhalt), .statstop(statstop), .stat_ovf(stat_ovf),
      .scratch(scratch), .mode(mode), .opc_ctl(opc_ctl), .idebug(idebug),
      .nop11(nop11), .stat_enb(stat_enb), .machrun(machrun), .status(status)
   );

   stat_counter stat_counter_i (
      .clk(clk), .reset(reset), .ld_stat(ld.stat), .spy_data(spy_wr.data),
      .state_fetch(state_fetch), .stat_enb(stat_enb), .stat_count(stat_count),
      .statstop(statstop), .stat_ovf(stat_ovf)
   );

   cycle_sequencer cycle_sequencer_i (
      .clk(clk), .reset(reset), .machrun(machrun), .mem_wait(mem_wait),
      .parity_error(parity_error), .errstop(mode.errstop), .boot(boot),
      .lpc_hold(opc_ctl.lpc_hold), .state_fetch(state_fetch), .waiting(waiting),
      .errhalt(errhalt), .upc(upc)
   );

endmodule

//--- source/cycle_sequencer.sv
/* Stand-in for the processor: one fetch every second clock while running.
   mem_wait holds the phase; a stopped machine restarts in the execute phase. */

module cycle_sequencer
   import mach_pkg::*;
(
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 machrun,
   input  logic                 mem_wait,
   input  logic                 parity_error,
   input  logic                 errstop,
   input  logic                 boot,
   input  logic                 lpc_hold,
   output logic                 state_fetch,
   output logic                 waiting,
   output logic                 errhalt,
   output logic [UPC_WIDTH-1:0] upc
);

   // 0 is execute, 1 is fetch
   logic phase;

   assign waiting     = mem_wait;
   assign state_fetch = phase & machrun & ~mem_wait;

   always_ff @(posedge clk) begin
      if (reset) begin
         phase <= 1'b0;
      end else if (mem_wait) begin
         phase <= phase;
      end else if (!machrun) begin
         phase <= 1'b0;
      end else begin
         phase <= ~phase;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         upc <= '0;
      end else if (state_fetch && !lpc_hold) begin
         upc <= upc + 1'b1;
      end
   end

   // Error halt latch
   always_ff @(posedge clk) begin
      if (reset || boot) begin
         errhalt <= 1'b0;
      end else if (parity_error && errstop) begin
         errhalt <= 1'b1;
      end
   end

endmodule

//--- source/mach_pkg.sv
/* Machine control and status structs.
   Field order matches the spy bit order, so a slice casts straight in. */

package mach_pkg;

   localparam int UPC_WIDTH = 14;

   // Spy bits 5 to 2
   typedef struct packed {
      logic promdisable;
      logic trapenb;
      logic stathenb;
      logic errstop;
   } mode_t;

   // Spy bits 2 to 0
   typedef struct packed {
      logic opcinh;
      logic opcclk;
      logic lpc_hold;
   } opc_ctl_t;

   // Spy bits 4 to 0
   typedef struct packed {
      logic stat_enb;
      logic idebug;
      logic nop11;
      logic step;
      logic run;
   } clk_ctl_t;

   // Read back in spy bits 6 to 0
   typedef struct packed {
      logic machrun;
      logic srun;
      logic ssdone;
      logic errhalt;
      logic stathalt;
      logic stat_ovf;
      logic promdisabled;
   } mach_status_t;

endpackage

//--- source/overlord.sv
/* Console control registers and machine-run level.
   Mode load wins over set_promdisable; boot wins over a clock-control write of run. */

module overlord
   import spy_pkg::*, mach_pkg::*;
(
   input  logic         clk,
   input  logic         reset,
   input  spy_ld_t      ld,
   input  logic [15:0]  spy_data,
   input  logic         boot,
   input  logic         set_promdisable,
   input  logic         state_fetch,
   input  logic         waiting,
   input  logic         errhalt,
   input  logic         statstop,
   input  logic         stat_ovf,
   output logic [15:0]  scratch,
   output mode_t        mode,
   output opc_ctl_t     opc_ctl,
   output logic         idebug,
   output logic         nop11,
   output logic         stat_enb,
   output logic         machrun,
   output mach_status_t status
);

   clk_ctl_t clk_ctl;
   logic     srun;
   logic     sstep;
   logic     ssdone;
   logic     promdisabled;
   logic     stathalt;

   always_ff @(posedge clk) begin
      if (reset) begin
         mode <= '0;
      end else if (ld.mode) begin
         mode <= mode_t'(spy_data[MODE_MSB:MODE_LSB]);
      end else if (set_promdisable) begin
         mode.promdisable <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         scratch <= SCRATCH_RESET;
      end else if (ld.scratch) begin
         scratch <= spy_data;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         opc_ctl <= '0;
      end else if (ld.opc) begin
         opc_ctl <= opc_ctl_t'(spy_data[OPC_MSB:0]);
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         clk_ctl <= '0;
      end else begin
         if (ld.clk) begin
            clk_ctl <= clk_ctl_t'(spy_data[CLK_MSB:0]);
         end
         if (boot) begin
            clk_ctl.run <= 1'b1;
         end
      end
   end

   // Run sync, single step and promdisabled delay
   always_ff @(posedge clk) begin
      if (reset) begin
         srun         <= 1'b0;
         sstep        <= 1'b0;
         ssdone       <= 1'b0;
         promdisabled <= 1'b0;
      end else begin
         srun         <= clk_ctl.run;
         sstep        <= clk_ctl.step;
         promdisabled <= mode.promdisable;
         // A fetch marks the step done, a fresh step rearms it
         if (state_fetch) begin
            ssdone <= sstep;
         end else if (clk_ctl.step && !sstep) begin
            ssdone <= 1'b0;
         end
      end
   end

   assign stathalt = statstop & mode.stathenb;
   assign machrun  = (sstep & ~ssdone) | (srun & ~errhalt & ~waiting & ~stathalt);

   assign idebug   = clk_ctl.idebug;
   assign nop11    = clk_ctl.nop11;
   assign stat_enb = clk_ctl.stat_enb;

   always_comb begin
      status.machrun      = machrun;
      status.srun         = srun;
      status.ssdone       = ssdone;
      status.errhalt      = errhalt;
      status.stathalt     = stathalt;
      status.stat_ovf     = stat_ovf;
      status.promdisabled = promdisabled;
   end

endmodule

//--- source/spy_pkg.sv
/* Spy port addresses, access structs and data field positions.
   Writes to the read-only addresses 1 and 2 are ignored. */

package spy_pkg;

   typedef logic [2:0] spy_addr_t;

   // Register map
   localparam spy_addr_t SPY_SCRATCH = 3'd0;
   localparam spy_addr_t SPY_STATUS  = 3'd1;
   localparam spy_addr_t SPY_UPC     = 3'd2;
   localparam spy_addr_t SPY_STAT    = 3'd3;
   localparam spy_addr_t SPY_MODE    = 3'd4;
   localparam spy_addr_t SPY_OPC     = 3'd5;
   localparam spy_addr_t SPY_CLK     = 3'd6;

   localparam logic [15:0] SCRATCH_RESET = 16'h1234;

   // Field positions within the 16-bit spy word
   localparam int MODE_MSB   = 5;
   localparam int MODE_LSB   = 2;
   localparam int OPC_MSB    = 2;
   localparam int CLK_MSB    = 4;
   localparam int STATUS_MSB = 6;

   typedef struct packed {
      logic        wr;
      spy_addr_t   addr;
      logic [15:0] data;
   } spy_wr_t;

   typedef struct packed {
      logic      rd;
      spy_addr_t addr;
   } spy_rd_t;

   // One-cycle load strobes
   typedef struct packed {
      logic scratch;
      logic mode;
      logic opc;
      logic clk;
      logic stat;
   } spy_ld_t;

endpackage

//--- source/spy_port.sv
/* Write decode is combinational, so loads land on the strobe edge.
   Read data is valid for one cycle after the read strobe; unmapped reads give zero. */

module spy_port
   import spy_pkg::*, mach_pkg::*;
(
   input  logic                 clk,
   input  logic                 reset,
   input  spy_wr_t              spy_wr,
   input  spy_rd_t              spy_rd,
   input  logic [15:0]          scratch,
   input  mach_status_t         status,
   input  logic [UPC_WIDTH-1:0] upc,
   input  logic [15:0]          stat_count,
   output spy_ld_t              ld,
   output logic [15:0]          spy_rdata,
   output logic                 spy_rvalid
);

   logic [15:0] rd_word;

   // One load pulse per write strobe
   always_comb begin
      ld.scratch = spy_wr.wr && (spy_wr.addr == SPY_SCRATCH);
      ld.stat    = spy_wr.wr && (spy_wr.addr == SPY_STAT);
      ld.mode    = spy_wr.wr && (spy_wr.addr == SPY_MODE);
      ld.opc     = spy_wr.wr && (spy_wr.addr == SPY_OPC);
      ld.clk     = spy_wr.wr && (spy_wr.addr == SPY_CLK);
   end

   // Read-back mux
   always_comb begin
      rd_word = '0;
      case (spy_rd.addr)
         SPY_SCRATCH: rd_word = scratch;
         SPY_STATUS:  rd_word[STATUS_MSB:0] = status;
         SPY_UPC:     rd_word[UPC_WIDTH-1:0] = upc;
         SPY_STAT:    rd_word = stat_count;
         default:     rd_word = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         spy_rvalid <= 1'b0;
      end else begin
         spy_rvalid <= spy_rd.rd;
      end
   end

   // Data word only changes on a read
   always_ff @(posedge clk) begin
      if (spy_rd.rd) begin
         spy_rdata <= rd_word;
      end
   end

endmodule

//--- source/stat_counter.sv
/* Counts enabled fetches. Overflow stays set until the next load;
   the stop request also drops when statistics are disabled. */

module stat_counter (
   input  logic        clk,
   input  logic        reset,
   input  logic        ld_stat,
   input  logic [15:0] spy_data,
   input  logic        state_fetch,
   input  logic        stat_enb,
   output logic [15:0] stat_count,
   output logic        statstop,
   output logic        stat_ovf
);

   logic        count_en;
   logic [16:0] count_next;

   assign count_en   = state_fetch & stat_enb;
   assign count_next = {1'b0, stat_count} + 17'd1;

   always_ff @(posedge clk) begin
      if (reset) begin
         stat_count <= '0;
         stat_ovf   <= 1'b0;
         statstop   <= 1'b0;
      end else if (ld_stat) begin
         stat_count <= spy_data;
         stat_ovf   <= 1'b0;
         statstop   <= 1'b0;
      end else begin
         if (count_en) begin
            stat_count <= count_next[15:0];
         end
         // Carry out marks the FFFF to 0 wrap
         if (count_en && count_next[16]) begin
            stat_ovf <= 1'b1;
            statstop <= 1'b1;
         end else if (!stat_enb) begin
            statstop <= 1'b0;
         end
      end
   end

endmodule

//--- verification/console_tb.sv
/* Directed testbench for console_top. Inputs change 1 time unit after the rising edge.
   Tests from single step on start from a fresh reset, so upc begins at zero. */

module console_tb
   import spy_pkg::*, mach_pkg::*;
();

   localparam int CLK_HALF     = 4;
   localparam int RESET_CYCLES = 10;
   localparam int WAIT_LIMIT   = 40;
   // Six tests of up to about 400 cycles each, with margin
   localparam int WATCHDOG_CYCLES = 2500;
   localparam logic [31:0] SEED   = 32'h19c8;

   logic                 clk;
   logic                 reset;
   spy_wr_t              spy_wr;
   spy_rd_t              spy_rd;
   logic                 boot;
   logic                 set_promdisable;
   logic                 mem_wait;
   logic                 parity_error;
   logic [15:0]          spy_rdata;
   logic                 spy_rvalid;
   opc_ctl_t             opc_ctl;
   mode_t                mode;
   logic                 idebug;
   logic                 nop11;
   mach_status_t         status;
   logic [UPC_WIDTH-1:0] upc;

   int          error_count;
   int          test_count;
   int          failed_tests;

   console_top console_top_i (
      .clk(clk), .reset(reset), .spy_wr(spy_wr), .spy_rd(spy_rd), .boot(boot),
      .set_promdisable(set_promdisable), .mem_wait(mem_wait),
      .parity_error(parity_error), .spy_rdata(spy_rdata), .spy_rvalid(spy_rvalid),
      .opc_ctl(opc_ctl), .mode(mode), .idebug(idebug), .nop11(nop11),
      .status(status), .upc(upc)
   );

   always #CLK_HALF clk = ~clk;

   // Advance n edges, landing just after the last one
   task automatic tick(input int n);
      repeat (n) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic apply_reset();
      reset = 1'b1;
      spy_wr = '0;
      spy_rd = '0;
      boot = 1'b0;
      set_promdisable = 1'b0;
      mem_wait = 1'b0;
      parity_error = 1'b0;
      tick(RESET_CYCLES);
      reset = 1'b0;
   endtask

   task automatic spy_write(input spy_addr_t addr, input logic [15:0] data);
      spy_wr.wr = 1'b1;
      spy_wr.addr = addr;
      spy_wr.data = data;
      tick(1);
      spy_wr.wr = 1'b0;
   endtask

   // Read data is valid for the cycle after the strobe edge
   task automatic spy_read(input spy_addr_t addr, output logic [15:0] data);
      spy_rd.rd = 1'b1;
      spy_rd.addr = addr;
      tick(1);
      spy_rd.rd = 1'b0;
      if (spy_rvalid !== 1'b1) begin
         $display("error at time %0t: no read valid after spy read of address %0d",
            $time, addr);
         error_count++;
      end
      data = spy_rdata;
   endtask

   task automatic pulse_boot();
      boot = 1'b1;
      tick(1);
      boot = 1'b0;
   endtask

   task automatic check_word(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
      if (got !== exp) begin
         $display("mismatch at time %0t: %s got %h expected %h", $time, name, got, exp);
         error_count++;
      end
   endtask

   task automatic check_status(input string name, input mach_status_t got,
                               input mach_status_t exp);
      if (got !== exp) begin
         $display("mismatch at time %0t: %s got %b expected %b", $time, name, got, exp);
         error_count++;
      end
   endtask

   task automatic check_mode(input string name, input mode_t got, input mode_t exp);
      if (got !== exp) begin
         $display("mismatch at time %0t: %s got %b expected %b", $time, name, got, exp);
         error_count++;
      end
   endtask

   task automatic check_opc(input string name, input opc_ctl_t got, input opc_ctl_t exp);
      if (got !== exp) begin
         $display("mismatch at time %0t: %s got %b expected %b", $time, name, got, exp);
         error_count++;
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("mismatch at time %0t: %s got %b expected %b", $time, name, got, exp);
         error_count++;
      end
   endtask

   task automatic check_upc(input string name, input logic [UPC_WIDTH-1:0] got,
                            input logic [UPC_WIDTH-1:0] exp);
      if (got !== exp) begin
         $display("mismatch at time %0t: %s got %0d expected %0d", $time, name, got, exp);
         error_count++;
      end
   endtask

   task automatic wait_machrun(input logic level);
      int n;
      n = 0;
      while (status.machrun !== level && n < WAIT_LIMIT) begin
         tick(1);
         n++;
      end
      if (status.machrun !== level) begin
         $display("error at time %0t: machrun did not reach %b within %0d cycles",
            $time, level, WAIT_LIMIT);
         error_count++;
      end
   endtask

   task automatic finish_test(input string name, input int start_errors);
      test_count++;
      if (error_count == start_errors) begin
         $display("test %s passed", name);
      end else begin
         failed_tests++;
         $display("test %s failed with %0d errors", name, error_count - start_errors);
      end
   endtask

   // Step low then high, then one fetch runs and machrun drops
   task automatic step_once();
      spy_write(SPY_CLK, 16'h0000);
      spy_write(SPY_CLK, 16'h0002);
      wait_machrun(1'b1);
      wait_machrun(1'b0);
   endtask

   task automatic test_scratch();
      int          start_errors;
      logic [15:0] rd;
      logic [15:0] val;
      start_errors = error_count;
      spy_read(SPY_SCRATCH, rd);
      check_word("spy_rdata", rd, 16'h1234);
      val = 16'($urandom());
      spy_write(SPY_SCRATCH, val);
      spy_read(SPY_SCRATCH, rd);
      check_word("spy_rdata", rd, val);
      finish_test("scratch", start_errors);
   endtask

   task automatic test_mode();
      int           start_errors;
      mach_status_t exp_st;
      start_errors = error_count;
      exp_st = '0;
      // trapenb and errstop in spy bits 4 and 2
      spy_write(SPY_MODE, 16'h0014);
      check_mode("mode", mode, 4'b0101);
      // idebug in spy bit 3, nop11 in spy bit 2
      spy_write(SPY_CLK, 16'h0008);
      check_bit("idebug", idebug, 1'b1);
      check_bit("nop11", nop11, 1'b0);
      spy_write(SPY_CLK, 16'h0004);
      check_bit("idebug", idebug, 1'b0);
      check_bit("nop11", nop11, 1'b1);
      set_promdisable = 1'b1;
      tick(1);
      set_promdisable = 1'b0;
      check_mode("mode", mode, 4'b1101);
      check_status("status", status, exp_st);
      tick(1);
      exp_st.promdisabled = 1'b1;
      check_status("status", status, exp_st);
      finish_test("mode", start_errors);
   endtask

   task automatic test_single_step();
      int           start_errors;
      mach_status_t exp_st;
      start_errors = error_count;
      apply_reset();
      repeat (3) begin
         step_once();
      end
      check_upc("upc", upc, 3);
      exp_st = '0;
      exp_st.ssdone = 1'b1;
      check_status("status", status, exp_st);
      // opcinh and lpc_hold in spy bits 2 and 0
      spy_write(SPY_OPC, 16'h0005);
      check_opc("opc_ctl", opc_ctl, 3'b101);
      step_once();
      check_upc("upc", upc, 3);
      finish_test("single_step", start_errors);
   endtask

   task automatic test_run_wait();
      int           start_errors;
      mach_status_t exp_st;
      start_errors = error_count;
      apply_reset();
      pulse_boot();
      exp_st = '0;
      check_status("status", status, exp_st);
      tick(1);
      exp_st.machrun = 1'b1;
      exp_st.srun = 1'b1;
      check_status("status", status, exp_st);
      tick(8);
      check_upc("upc", upc, 4);
      mem_wait = 1'b1;
      tick(10);
      check_upc("upc", upc, 4);
      mem_wait = 1'b0;
      tick(4);
      check_upc("upc", upc, 6);
      finish_test("run_wait", start_errors);
   endtask

   task automatic test_stat_halt();
      int           start_errors;
      logic [15:0]  rd;
      mach_status_t exp_st;
      start_errors = error_count;
      apply_reset();
      spy_write(SPY_STAT, 16'hFFFD);
      // stathenb in spy bit 3, stat_enb in spy bit 4
      spy_write(SPY_MODE, 16'h0008);
      spy_write(SPY_CLK, 16'h0010);
      pulse_boot();
      wait_machrun(1'b1);
      wait_machrun(1'b0);
      check_upc("upc", upc, 3);
      exp_st = '0;
      exp_st.srun = 1'b1;
      exp_st.stathalt = 1'b1;
      exp_st.stat_ovf = 1'b1;
      check_status("status", status, exp_st);
      tick(6);
      check_upc("upc", upc, 3);
      spy_read(SPY_STAT, rd);
      check_word("spy_rdata", rd, 16'h0000);
      finish_test("stat_halt", start_errors);
   endtask

   task automatic test_err_halt();
      int           start_errors;
      logic [15:0]  rd;
      mach_status_t exp_st;
      start_errors = error_count;
      apply_reset();
      spy_write(SPY_MODE, 16'h0004);
      pulse_boot();
      wait_machrun(1'b1);
      parity_error = 1'b1;
      tick(1);
      parity_error = 1'b0;
      exp_st = '0;
      exp_st.srun = 1'b1;
      exp_st.errhalt = 1'b1;
      check_status("status", status, exp_st);
      // srun in bit 5, errhalt in bit 3
      spy_read(SPY_STATUS, rd);
      check_word("spy_rdata", rd, 16'h0028);
      pulse_boot();
      exp_st.errhalt = 1'b0;
      exp_st.machrun = 1'b1;
      check_status("status", status, exp_st);
      finish_test("err_halt", start_errors);
   endtask

   initial begin
      clk = 1'b0;
      error_count = 0;
      test_count = 0;
      failed_tests = 0;
      void'($urandom(SEED));
      apply_reset();
      test_scratch();
      test_mode();
      test_single_step();
      test_run_wait();
      test_stat_halt();
      test_err_halt();
      $display("tests run %0d, tests failed %0d, errors %0d",
         test_count, failed_tests, error_count);
      if (error_count == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #(WATCHDOG_CYCLES * 2 * CLK_HALF);
      $display("error: watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
      $display("TEST FAILED");
      $finish;
   end

endmodule
